// File: vlog.f
+incdir+src
src/host_mem_pkg.sv
src/host_mem_rd_issue.sv
src/host_mem_rob_rd.sv
src/host_mem_rd_drain.sv
src/host_chan_as_avalon_mem.sv
tb/tb_host_mem_model.sv
tb/tb_host_chan_as_avalon_mem.sv

// File: Bender.yml
package:
  name: host_chan_as_avalon_mem

sources:
  - include_dirs:
      - src
    files:
      - src/host_mem_pkg.sv
      - src/host_mem_rd_issue.sv
      - src/host_mem_rob_rd.sv
      - src/host_mem_rd_drain.sv
      - src/host_chan_as_avalon_mem.sv

  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_host_mem_model.sv
      - tb/tb_host_chan_as_avalon_mem.sv

// File: tb/tb_host_chan_as_avalon_mem.sv
// Testbench top that drives random Avalon reads against an out-of-order host model and checks order
`timescale 1ns/1ps

`include "host_mem_cfg.svh"

module tb_host_chan_as_avalon_mem;

    localparam int DEPTH       = `HOST_MEM_ROB_DEPTH;
    localparam int TOTAL_READS = 400;
    localparam int FIRST_READS = 200;
    localparam int TIMEOUT     = 4000;

    logic                        afu_clk = 1'b0;
    logic                        rst_n = 1'b0;
    logic                        read = 1'b0;
    logic [`HOST_MEM_ADDR_W-1:0] address = '0;
    logic                        hold_rsp = 1'b0;
    logic                        waitrequest;
    logic                        readdatavalid;
    logic [`HOST_MEM_DATA_W-1:0] readdata;
    logic                        host_rd_req_valid;
    host_mem_pkg::t_host_rd_req  host_rd_req;
    logic                        host_almost_full;
    logic                        host_rd_rsp_valid;
    host_mem_pkg::t_host_rd_rsp  host_rd_rsp;
    logic                        lost_req;

    // Reference model holding the addresses in acceptance order
    logic [`HOST_MEM_ADDR_W-1:0] ref_q[$];
    logic [`HOST_MEM_ADDR_W-1:0] prev_addr = '0;
    logic [31:0]                 lfsr_state = 32'h0de9_10f2;
    logic                        prev_accept = 1'b0;
    logic                        accept_at_edge = 1'b0;
    int                          accepted_cnt = 0;
    int                          drained_cnt = 0;
    int                          issued_cnt = 0;

    host_chan_as_avalon_mem i_dut
    (
        .afu_clk           (afu_clk),
        .rst_n             (rst_n),
        .read              (read),
        .address           (address),
        .waitrequest       (waitrequest),
        .readdatavalid     (readdatavalid),
        .readdata          (readdata),
        .host_rd_req_valid (host_rd_req_valid),
        .host_rd_req       (host_rd_req),
        .host_almost_full  (host_almost_full),
        .host_rd_rsp_valid (host_rd_rsp_valid),
        .host_rd_rsp       (host_rd_rsp)
    );

    tb_host_mem_model i_host
    (
        .afu_clk           (afu_clk),
        .rst_n             (rst_n),
        .hold_rsp          (hold_rsp),
        .host_rd_req_valid (host_rd_req_valid),
        .host_rd_req       (host_rd_req),
        .host_almost_full  (host_almost_full),
        .host_rd_rsp_valid (host_rd_rsp_valid),
        .host_rd_rsp       (host_rd_rsp),
        .lost_req          (lost_req)
    );

    initial
    begin
        forever #50 afu_clk = ~afu_clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that is stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Host memory holds the address XOR 16'h5a3c replicated to 32 bits
    function automatic logic [`HOST_MEM_DATA_W-1:0] expected_data(
        input logic [`HOST_MEM_ADDR_W-1:0] addr);
        return {2{addr ^ 16'h5a3c}};
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_error(input string msg);
        stop_run($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    // ==================================================
    // Monitor and checks
    // ==================================================

    // Sampled mid-cycle; an accept seen here takes effect at the next rising edge
    always @(negedge afu_clk)
    begin
        logic [`HOST_MEM_ADDR_W-1:0] exp_addr;
        if (!rst_n)
        begin
            assert (waitrequest && !readdatavalid && !host_rd_req_valid)
            else report_error("waitrequest low or a valid strobe high during reset");
        end
        else
        begin
            assert (!lost_req)
            else stop_run("The host model got a request beyond its almost-full slack and lost it");
            // The host request follows its acceptance by exactly one cycle
            assert (host_rd_req_valid == prev_accept)
            else report_error($sformatf("host_rd_req_valid %b, expected %b",
                host_rd_req_valid, prev_accept));
            if (host_rd_req_valid)
            begin
                assert (host_rd_req.addr == prev_addr && host_rd_req.tag == issued_cnt % DEPTH)
                else report_error($sformatf("host request tag %0d addr %h, expected tag %0d addr %h",
                    host_rd_req.tag, host_rd_req.addr, issued_cnt % DEPTH, prev_addr));
                issued_cnt++;
            end
            // A full buffer or host almost-full holds the AFU off
            if (accepted_cnt - drained_cnt == DEPTH || host_almost_full)
            begin
                assert (waitrequest)
                else report_error("waitrequest low with the buffer full or the host almost-full");
            end
            if (readdatavalid)
            begin
                assert (ref_q.size() > 0)
                else report_error("readdatavalid without a matching accepted read");
                exp_addr = ref_q.pop_front();
                assert (readdata == expected_data(exp_addr))
                else report_error($sformatf("readdata %h, expected %h for address %h",
                    readdata, expected_data(exp_addr), exp_addr));
                drained_cnt++;
            end
            prev_accept    = read && !waitrequest;
            prev_addr      = address;
            accept_at_edge = prev_accept;
            if (prev_accept)
            begin
                ref_q.push_back(address);
                accepted_cnt++;
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    // Random reads, each held until it is accepted as Avalon requires
    task automatic run_random_reads(input int n_reads);
        int done;
        int guard;
        done = 0;
        guard = 0;
        while (done < n_reads)
        begin
            @(posedge afu_clk);
            #1;
            guard++;
            if (guard > TIMEOUT)
                stop_run("Timed out while issuing random reads");
            if (read && accept_at_edge)
            begin
                done++;
                read = 1'b0;
            end
            if (!read && done < n_reads && rand_bits(2) != 0)
            begin
                read = 1'b1;
                address = `HOST_MEM_ADDR_W'(rand_bits(`HOST_MEM_ADDR_W));
            end
        end
    endtask

    task automatic wait_drained();
        int guard;
        guard = 0;
        while (ref_q.size() != 0)
        begin
            @(posedge afu_clk);
            guard++;
            if (guard > TIMEOUT)
                stop_run("Timed out waiting for outstanding reads to drain");
        end
    endtask

    // With every response held, only DEPTH reads go in; one more waits for a drain
    task automatic check_full_stall();
        int start;
        int drain_start;
        int guard;
        @(posedge afu_clk);
        #1;
        hold_rsp = 1'b1;
        start = accepted_cnt;
        read = 1'b1;
        address = `HOST_MEM_ADDR_W'(rand_bits(`HOST_MEM_ADDR_W));
        repeat (3 * DEPTH)
        begin
            @(posedge afu_clk);
            #1;
            if (accept_at_edge)
                address = `HOST_MEM_ADDR_W'(rand_bits(`HOST_MEM_ADDR_W));
        end
        assert (accepted_cnt - start == DEPTH)
        else report_error($sformatf("%0d reads accepted with responses held, expected %0d",
            accepted_cnt - start, DEPTH));
        drain_start = drained_cnt;
        hold_rsp = 1'b0;
        guard = 0;
        while (!accept_at_edge)
        begin
            @(posedge afu_clk);
            #1;
            guard++;
            if (guard > TIMEOUT)
                stop_run("Timed out waiting for the stalled read to be accepted");
        end
        assert (drained_cnt > drain_start)
        else report_error("read accepted with a full buffer before any readdatavalid");
        read = 1'b0;
    endtask

    initial
    begin
        int guard;
        repeat (2) @(posedge afu_clk);
        #1;
        rst_n = 1'b1;
        guard = 0;
        while (waitrequest)
        begin
            @(negedge afu_clk);
            guard++;
            if (guard > 20)
                stop_run("waitrequest did not fall after reset was released");
        end
        run_random_reads(FIRST_READS);
        wait_drained();
        check_full_stall();
        run_random_reads(TOTAL_READS - FIRST_READS - DEPTH - 1);
        wait_drained();
        // Idle cycles let a stray readdatavalid or a late lost request reach the monitor
        repeat (2 * DEPTH) @(posedge afu_clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: tb/tb_host_mem_model.sv
// Behavioral host for the testbench that takes tagged reads and answers them late and out of order
`timescale 1ns/1ps

`include "host_mem_cfg.svh"

module tb_host_mem_model
(
    input  logic                            afu_clk,
    input  logic                            rst_n,
    // Holds every response back and keeps almost-full low while high
    input  logic                            hold_rsp,
    input  logic                            host_rd_req_valid,
    input  host_mem_pkg::t_host_rd_req      host_rd_req,
    output logic                            host_almost_full,
    output logic                            host_rd_rsp_valid,
    output host_mem_pkg::t_host_rd_rsp      host_rd_rsp,
    // Sticky flag set when a request arrives beyond the almost-full slack
    output logic                            lost_req
);

    logic [31:0]                lfsr_state = 32'h0de9_10f2;
    host_mem_pkg::t_host_rd_req pend_req[$];
    int unsigned                pend_due[$];
    int unsigned                cycle = 0;
    int unsigned                af_taken = 0;
    int unsigned                af_left = 0;
    logic                       lost_q = 1'b0;

    assign lost_req = lost_q;

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that is stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Host memory holds the address XOR 16'h5a3c replicated to 32 bits
    function automatic logic [`HOST_MEM_DATA_W-1:0] line_data(
        input logic [`HOST_MEM_ADDR_W-1:0] addr);
        return {2{addr ^ 16'h5a3c}};
    endfunction

    // ==================================================
    // Request intake
    // ==================================================

    // Requests are taken mid-cycle, where the DUT outputs have settled
    always @(negedge afu_clk)
    begin
        // Count what arrives while almost-full is up
        if (!host_almost_full)
            af_taken = 0;
        else if (host_rd_req_valid)
            af_taken++;
        if (rst_n && host_rd_req_valid)
        begin
            if (af_taken > `HOST_MEM_AF_SLACK)
                lost_q <= 1'b1;
            else
            begin
                pend_req.push_back(host_rd_req);
                pend_due.push_back(cycle + rand_bits(3));
            end
        end
    end

    // ==================================================
    // Responses and almost-full
    // ==================================================

    // Outputs change two time units after the edge, once the testbench has set hold_rsp
    initial
    begin
        int unsigned idx;
        host_almost_full  = 1'b0;
        host_rd_rsp_valid = 1'b0;
        host_rd_rsp       = '0;
        forever
        begin
            @(posedge afu_clk);
            #2;
            cycle++;
            host_rd_rsp_valid = 1'b0;
            if (!rst_n || hold_rsp)
            begin
                host_almost_full = 1'b0;
                af_left = 0;
            end
            else
            begin
                // Almost-full comes in short bursts of one to four cycles
                if (af_left > 0)
                    af_left--;
                else if (rand_bits(4) == 0)
                    af_left = 1 + rand_bits(2);
                host_almost_full = (af_left > 0);
                // A random pending entry answers once its delay has run out
                if (pend_req.size() > 0 && rand_bits(1) == 1)
                begin
                    idx = rand_bits(3) % pend_req.size();
                    if (pend_due[idx] <= cycle)
                    begin
                        host_rd_rsp.tag   = pend_req[idx].tag;
                        host_rd_rsp.data  = line_data(pend_req[idx].addr);
                        host_rd_rsp_valid = 1'b1;
                        pend_req.delete(idx);
                        pend_due.delete(idx);
                    end
                end
            end
        end
    end

endmodule

// File: src/host_chan_as_avalon_mem.sv
// Top level that maps a tagged, out-of-order host read channel to an in-order Avalon read port
`timescale 1ns/1ps

`include "host_mem_cfg.svh"

module host_chan_as_avalon_mem
(
    input  logic                            afu_clk,
    input  logic                            rst_n,

    // ==================================================
    // AFU side in Avalon style
    // ==================================================
    input  logic                            read,
    input  logic [`HOST_MEM_ADDR_W-1:0]     address,
    output logic                            waitrequest,
    output logic                            readdatavalid,
    output logic [`HOST_MEM_DATA_W-1:0]     readdata,

    // ==================================================
    // Host side with the tagged channel
    // ==================================================
    output logic                            host_rd_req_valid,
    output host_mem_pkg::t_host_rd_req      host_rd_req,
    input  logic                            host_almost_full,
    input  logic                            host_rd_rsp_valid,
    input  host_mem_pkg::t_host_rd_rsp      host_rd_rsp
);

    // Consumer to buffer lookup
    logic [`HOST_MEM_TAG_W-1:0]  head_idx;

    // Buffer to consumer
    logic                        head_valid;
    logic [`HOST_MEM_DATA_W-1:0] head_data;

    // Consumer to buffer and producer with one pulse per drained read
    logic                        head_release;

    // Tags reads and sends them to the host
    host_mem_rd_issue i_rd_issue
    (
        .afu_clk           (afu_clk),
        .rst_n             (rst_n),
        .read              (read),
        .address           (address),
        .waitrequest       (waitrequest),
        .head_release      (head_release),
        .host_almost_full  (host_almost_full),
        .host_rd_req_valid (host_rd_req_valid),
        .host_rd_req       (host_rd_req)
    );

    // Sorts responses by tag
    host_mem_rob_rd i_rob_rd
    (
        .afu_clk      (afu_clk),
        .rst_n        (rst_n),
        .rsp_valid    (host_rd_rsp_valid),
        .rsp          (host_rd_rsp),
        .head_idx     (head_idx),
        .head_release (head_release),
        .head_valid   (head_valid),
        .head_data    (head_data)
    );

    // Returns data in issue order
    host_mem_rd_drain i_rd_drain
    (
        .afu_clk       (afu_clk),
        .rst_n         (rst_n),
        .head_valid    (head_valid),
        .head_data     (head_data),
        .head_idx      (head_idx),
        .head_release  (head_release),
        .readdatavalid (readdatavalid),
        .readdata      (readdata)
    );

endmodule

// File: src/host_mem_rd_drain.sv
// Consumer that walks the buffer head in issue order, returns data to the AFU and frees slots
`timescale 1ns/1ps

`include "host_mem_cfg.svh"

module host_mem_rd_drain
(
    input  logic                            afu_clk,
    input  logic                            rst_n,

    // Buffer head
    input  logic                            head_valid,
    input  logic [`HOST_MEM_DATA_W-1:0]     head_data,
    output logic [`HOST_MEM_TAG_W-1:0]      head_idx,
    output logic                            head_release,

    // In-order Avalon read data without back-pressure
    output logic                            readdatavalid,
    output logic [`HOST_MEM_DATA_W-1:0]     readdata
);

    host_mem_pkg::t_drain_state state;
    host_mem_pkg::t_drain_state state_next;

    // ==================================================
    // FSM
    // ==================================================

    // Emit in the cycle after the head slot is seen valid
    // Back-to-back valid slots keep the FSM in DRAIN_EMIT, one per cycle
    always_comb
    begin
        if (head_valid)
            state_next = host_mem_pkg::DRAIN_EMIT;
        else
            state_next = host_mem_pkg::DRAIN_IDLE;
    end

    // State and head pointer
    // The head moves as soon as its slot is taken, which exposes the
    // next slot to the buffer lookup in the very next cycle
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= host_mem_pkg::DRAIN_IDLE;
            head_idx <= '0;
        end
        else
        begin
            state <= state_next;
            if (head_valid)
                head_idx <= head_idx + 1'b1;
        end
    end

    // ==================================================
    // Outputs
    // ==================================================

    // Captured with the head so it lines up with readdatavalid
    always_ff @(posedge afu_clk)
    begin
        if (head_valid)
            readdata <= head_data;
    end

    // The slot goes back to the buffer and producer as the AFU sees it
    assign readdatavalid = (state == host_mem_pkg::DRAIN_EMIT);
    assign head_release  = (state == host_mem_pkg::DRAIN_EMIT);

endmodule

// File: src/host_mem_rob_rd.sv
// Read reorder buffer that stores host responses by tag and shows the consumer its head slot
`timescale 1ns/1ps

`include "host_mem_cfg.svh"

module host_mem_rob_rd
(
    input  logic                            afu_clk,
    input  logic                            rst_n,

    // Host responses in any order
    input  logic                            rsp_valid,
    input  host_mem_pkg::t_host_rd_rsp      rsp,

    // Consumer side
    input  logic [`HOST_MEM_TAG_W-1:0]      head_idx,
    input  logic                            head_release,
    output logic                            head_valid,
    output logic [`HOST_MEM_DATA_W-1:0]     head_data
);

    logic [`HOST_MEM_DATA_W-1:0] slot_data [`HOST_MEM_ROB_DEPTH];
    logic [`HOST_MEM_ROB_DEPTH-1:0] slot_valid;
    logic [`HOST_MEM_TAG_W-1:0] rel_idx;

    // ==================================================
    // Slot bookkeeping
    // ==================================================

    // The consumer advances its head at the same edge it captures the
    // data, so the slot released in the following cycle sits one behind
    assign rel_idx = head_idx - 1'b1;

    // A tag only returns once its slot has been released and reissued,
    // so a set and a clear never hit the same slot in one cycle
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
            slot_valid <= '0;
        else
        begin
            if (head_release)
                slot_valid[rel_idx] <= 1'b0;
            if (rsp_valid)
                slot_valid[rsp.tag] <= 1'b1;
        end
    end

    // Data array written by tag
    always_ff @(posedge afu_clk)
    begin
        if (rsp_valid)
            slot_data[rsp.tag] <= rsp.data;
    end

    // ==================================================
    // Head presentation
    // ==================================================

    // Raw view of the slot the consumer points at
    // The consumer alone decides when to take it
    assign head_valid = slot_valid[head_idx];
    assign head_data  = slot_data[head_idx];

endmodule

// File: src/host_mem_rd_issue.sv
// Producer that accepts Avalon reads from the AFU, tags them in order and registers them to the host
`timescale 1ns/1ps

`include "host_mem_cfg.svh"

module host_mem_rd_issue
(
    input  logic                            afu_clk,
    input  logic                            rst_n,

    // AFU read request side
    input  logic                            read,
    input  logic [`HOST_MEM_ADDR_W-1:0]     address,
    output logic                            waitrequest,

    // One pulse per slot handed back by the consumer
    input  logic                            head_release,

    // Host request channel
    input  logic                            host_almost_full,
    output logic                            host_rd_req_valid,
    output host_mem_pkg::t_host_rd_req      host_rd_req
);

    // The count needs one more bit than a tag so that it can hold the full depth
    localparam int CNT_W = `HOST_MEM_TAG_W + 1;
    localparam logic [CNT_W-1:0] MAX_OUT = CNT_W'(`HOST_MEM_ROB_DEPTH);

    logic                         ready_q;
    logic [`HOST_MEM_TAG_W-1:0]   next_tag;
    logic [CNT_W-1:0]             out_cnt;
    logic                         buf_full;
    logic                         accept;

    // ==================================================
    // Flow control toward the AFU
    // ==================================================

    // Every slot is owned by a read that has not yet drained
    assign buf_full = (out_cnt == MAX_OUT);

    // The request register holds at most one request past almost-full,
    // which stays inside the host's slack
    assign waitrequest = !ready_q || host_almost_full || buf_full;

    // Avalon acceptance means read high with waitrequest low at the edge
    assign accept = read && !waitrequest;

    // Holds waitrequest high through reset and the first cycle after it
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
            ready_q <= 1'b0;
        else
            ready_q <= 1'b1;
    end

    // ==================================================
    // Tag allocation and outstanding count
    // ==================================================

    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            next_tag <= '0;
            out_cnt  <= '0;
        end
        else
        begin
            // Tags wrap naturally since the depth is a power of two
            if (accept)
                next_tag <= next_tag + 1'b1;

            // Acceptance and release in the same cycle cancel out
            if (accept && !head_release)
                out_cnt <= out_cnt + 1'b1;
            else if (!accept && head_release)
                out_cnt <= out_cnt - 1'b1;
        end
    end

    // ==================================================
    // Request register toward the host
    // ==================================================

    // The request strobe follows each acceptance by one cycle
    always_ff @(posedge afu_clk or negedge rst_n)
    begin
        if (!rst_n)
            host_rd_req_valid <= 1'b0;
        else
            host_rd_req_valid <= accept;
    end

    // Tag and address of the read accepted at this edge
    always_ff @(posedge afu_clk)
    begin
        if (accept)
        begin
            host_rd_req.tag  <= next_tag;
            host_rd_req.addr <= address;
        end
    end

endmodule

// File: src/host_mem_pkg.sv
// Shared types of the host memory read channel, referenced by scoped name from each block

`include "host_mem_cfg.svh"

package host_mem_pkg;

    // ==================================================
    // Host channel payloads
    // ==================================================

    // Read request toward the host
    // The tag names the buffer slot that will hold the response
    typedef struct packed {
        logic [`HOST_MEM_TAG_W-1:0]  tag;
        logic [`HOST_MEM_ADDR_W-1:0] addr;
    } t_host_rd_req;

    // Read response from the host, possibly out of issue order
    typedef struct packed {
        logic [`HOST_MEM_TAG_W-1:0]  tag;
        logic [`HOST_MEM_DATA_W-1:0] data;
    } t_host_rd_rsp;

    // ==================================================
    // Consumer FSM
    // ==================================================

    // DRAIN_EMIT is the cycle in which the captured head data is
    // presented to the AFU and the head slot is handed back
    typedef enum logic [0:0] {
        DRAIN_IDLE = 1'b0,
        DRAIN_EMIT = 1'b1
    } t_drain_state;

endpackage

// File: src/host_mem_cfg.svh
// Build-time sizes for the host memory read channel, included by the package, RTL and testbench
`ifndef HOST_MEM_CFG_SVH
`define HOST_MEM_CFG_SVH

// Number of reads that may be outstanding at the host, and number of buffer slots
`define HOST_MEM_ROB_DEPTH 8

// Tag width; a tag is the buffer slot index, so depth must equal 2**tag width
`define HOST_MEM_TAG_W 3

// Line address width on the AFU and host sides
`define HOST_MEM_ADDR_W 16

// Read data width
`define HOST_MEM_DATA_W 32

// Requests the host still takes after it raises almost-full
`define HOST_MEM_AF_SLACK 2

`endif
